// File: ccu_chk.sv
`timescale 1ns/10ps

module ccu_chk import ccu_pkg::*; #(
    parameter int NUM_PEB = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  loader_state_e      ld_state,     // loader fsm
    input  seq_state_e         sq_state,     // sequencer fsm
    input  logic               push,
    input  logic               full,
    input  logic               gb_cfg_val,
    input  logic               gb_cfg_rdy,
    input  logic               layer_fnh,
    input  logic [NUM_PEB-1:0] peb_next_block,
    input  logic [NUM_PEB-1:0] peb_reset_wei,
    input  logic [NUM_PEB-1:0] peb_reset_act
);

    // ======================================================================
    // handshakes
    // ======================================================================
    gb_val_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gb_cfg_val) |-> $past(gb_cfg_rdy))
        else $error("gb_cfg_val dropped without gb_cfg_rdy");

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("config fifo written while full");

    // sequencer only busy while the loader holds a loaded run
    seq_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (sq_state != SQ_IDLE) |-> (ld_state == LD_HOLD))
        else $error("sequencer busy while loader not holding");

    // ======================================================================
    // peb fan-out and layer end
    // ======================================================================
    peb_bits_equal: assert property (@(posedge clk) disable iff (!rst_n)
        (peb_next_block == '0 || peb_next_block == '1) &&
        (peb_reset_wei == '0 || peb_reset_wei == '1) &&
        (peb_reset_act == '0 || peb_reset_act == '1))
        else $error("peb pulse bits differ");

    fnh_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        layer_fnh |-> (sq_state == SQ_RUN))
        else $error("layer_fnh outside the run state");

endmodule

bind ccu_top ccu_chk #(.NUM_PEB(NUM_PEB)) ccu_chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ld_state       (cfg_loader_i.state),
    .sq_state       (loop_sequencer_i.state),
    .push           (cfg_if.push),
    .full           (cfg_if.full),
    .gb_cfg_val     (gb_cfg_val),
    .gb_cfg_rdy     (gb_cfg_rdy),
    .layer_fnh      (layer_fnh),
    .peb_next_block (peb_next_block),
    .peb_reset_wei  (peb_reset_wei),
    .peb_reset_act  (peb_reset_act)
);

// File: ccu_pkg.sv
package ccu_pkg;

    // ======================================================================
    // loop count fields, each holds the last index of its loop
    // ======================================================================
    localparam int BLK_W      = 4;   // blocks per frame
    localparam int FRM_W      = 4;   // frames per feature group
    localparam int GRP_W      = 4;   // feature groups per patch
    localparam int PAT_W      = 4;   // patches per layer

    // global buffer fields
    localparam int ALLOC_W    = 4;   // sram banks per data kind
    localparam int LOOP_WEI_W = 12;  // patch * frame sized
    localparam int LOOP_ACT_W = 8;

    typedef logic [ALLOC_W-1:0]    alloc_t;
    typedef logic [LOOP_WEI_W-1:0] loop_wei_t;
    typedef logic [LOOP_ACT_W-1:0] loop_act_t;

    // one word per layer, msb first
    typedef struct packed {
        logic [BLK_W-1:0] num_block;
        logic [FRM_W-1:0] num_frame;
        logic [GRP_W-1:0] num_ftrgrp;
        logic [PAT_W-1:0] num_patch;
        alloc_t           alloc_wei;
        alloc_t           alloc_act;
        loop_wei_t        loop_wei;
        loop_act_t        loop_act;
    } cfg_word_t;

    localparam int CFG_W = $bits(cfg_word_t);  // 44 bits

    // ======================================================================
    // fsm states
    // ======================================================================
    typedef enum logic [1:0] {
        LD_IDLE,    // waiting for start
        LD_FILL,    // accepting words
        LD_HOLD     // buffer loaded, run in progress
    } loader_state_e;

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_POP,         // fetch next layer word
        SQ_RUN,         // walking the block loops
        SQ_WAIT_CLEAR   // layer done, pooling draining
    } seq_state_e;

endpackage

// File: ccu_stim.txt
// cols: cfg word {num_block num_frame num_ftrgrp num_patch alloc_wei alloc_act loop_wei loop_act}
// then the number of blocks expected in that layer; three runs of four layers
1100350a412 4
00001200101 1
21117c3ff80 18
02109412345 6
// run 1
10112a0f00f 8
3002e1777aa c
010155abc3c 4
1111f0800ff 10
// run 2
00126b2469d 6
200088fff00 3
03004d0c071 4
1201b25a5e6 c

// File: ccu_tb.sv
`timescale 1ns/10ps

module ccu_tb import ccu_pkg::*;;

    localparam int NUM_PEB = 4;
    localparam int DEPTH   = 4;             // words, and layers, per run
    localparam int NRUN    = 3;
    localparam int NWORD   = NRUN * DEPTH;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               cfg_val;
    logic [CFG_W-1:0]   cfg_data;
    logic               cfg_rdy;
    logic               gb_cfg_val;
    logic               gb_cfg_rdy;
    alloc_t             gb_alloc_wei;
    alloc_t             gb_alloc_act;
    loop_wei_t          gb_loop_wei;
    loop_act_t          gb_loop_act;
    logic [NUM_PEB-1:0] peb_fnh_block;
    logic [NUM_PEB-1:0] peb_next_block;
    logic [NUM_PEB-1:0] peb_reset_wei;
    logic [NUM_PEB-1:0] peb_reset_act;
    logic               gb_pullback_wei;
    logic               gb_pullback_act;
    logic               layer_fnh;
    logic               pool_clear_up;

    logic [CFG_W-1:0] stim [2*NWORD];       // word, expected blocks
    int   limit;
    int   errors    = 0;
    int   checks    = 0;
    int   acc_cnt   = 0;                    // words accepted so far
    int   hs_idx    = 0;                    // gb handshakes so far
    int   layer_idx = 0;                    // layers cleared so far
    int   nb_cnt    = 0;
    int   rw_cnt    = 0;
    int   ra_cnt    = 0;
    int   pbw_cnt   = 0;
    int   pba_cnt   = 0;
    int   fnh_cnt   = 0;
    logic in_clear  = 1'b0;                 // between layer_fnh and clear-up

    ccu_top #(.NUM_PEB(NUM_PEB), .FIFO_DEPTH(DEPTH)) ccu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_eq(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic cfg_word_t word_at(input int n);
        return cfg_word_t'(stim[2*n]);
    endfunction

    function automatic int iters(input logic [3:0] last);
        return int'(last) + 1;              // field holds the last index
    endfunction

    function automatic int blocks(input cfg_word_t w);
        return iters(w.num_block) * iters(w.num_frame) *
               iters(w.num_ftrgrp) * iters(w.num_patch);
    endfunction

    // start pulse, then offer one run of words; a junk word trails the last
    task automatic load_run(input int r);
        int k;
        k        = 0;
        start    = 1'b1;
        cfg_val  = 1'b1;                    // offered early, must be ignored
        cfg_data = stim[2*(r*DEPTH)];
        @(posedge clk);
        #1 start = 1'b0;
        while (k < DEPTH) begin
            @(negedge clk);
            if (cfg_rdy) begin
                k++;
            end
            @(posedge clk);
            #1;
            cfg_data = (k < DEPTH) ? stim[2*(r*DEPTH+k)] : ~stim[0];
        end
        repeat (3) @(posedge clk);
        #1 cfg_val = 1'b0;
    endtask

    // ======================================================================
    // pe, global buffer and pooling models
    // ======================================================================
    initial begin : pe_model
        logic [NUM_PEB-1:0] nb;
        int                 dly [NUM_PEB];
        peb_fnh_block = '0;
        for (int i = 0; i < NUM_PEB; i++) begin
            dly[i] = 0;
        end
        forever begin
            @(negedge clk);
            nb = peb_next_block;
            @(posedge clk);
            #1;
            for (int i = 0; i < NUM_PEB; i++) begin
                if (nb[i]) begin
                    peb_fnh_block[i] = 1'b0;            // new block started
                    dly[i] = 1 + int'($urandom % 6);
                end else if (dly[i] > 0) begin
                    dly[i]--;
                    if (dly[i] == 0) begin
                        peb_fnh_block[i] = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : gb_model
        int stall;
        gb_cfg_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (gb_cfg_val) begin
                stall = int'($urandom % 4);
                repeat (stall) @(posedge clk);
                @(posedge clk);
                #1 gb_cfg_rdy = 1'b1;           // one-cycle ready
                @(posedge clk);
                #1 gb_cfg_rdy = 1'b0;
            end
        end
    end

    initial begin : pool_model
        int dly;
        pool_clear_up = 1'b0;
        forever begin
            @(negedge clk);
            if (layer_fnh) begin
                dly = 1 + int'($urandom % 4);
                repeat (dly) @(posedge clk);
                #1 pool_clear_up = 1'b1;
                @(posedge clk);
                #1 pool_clear_up = 1'b0;
            end
        end
    end

    // ======================================================================
    // monitor, mid-cycle sampling
    // ======================================================================
    always @(negedge clk) begin : monitor
        cfg_word_t w;
        int        fgp;                     // frame x group x patch iterations
        int        gp;
        if (rst_n) begin
            if (start) begin
                check_eq("cfg_rdy before start", int'(cfg_rdy), 0);
                check_eq("gb_cfg_val while idle", int'(gb_cfg_val), 0);
            end
            if (acc_cnt > layer_idx && acc_cnt % DEPTH == 0) begin
                check_eq("cfg_rdy while run loaded", int'(cfg_rdy), 0);
            end
            if (cfg_val && cfg_rdy) begin
                acc_cnt++;
            end
            if (gb_cfg_val && gb_cfg_rdy) begin
                w = word_at(hs_idx % NWORD);
                check_eq("gb_alloc_wei", int'(gb_alloc_wei), int'(w.alloc_wei));
                check_eq("gb_alloc_act", int'(gb_alloc_act), int'(w.alloc_act));
                check_eq("gb_loop_wei", int'(gb_loop_wei), int'(w.loop_wei));
                check_eq("gb_loop_act", int'(gb_loop_act), int'(w.loop_act));
                hs_idx++;
            end
            if (in_clear) begin
                check_eq("peb_next_block before clear-up", int'(|peb_next_block), 0);
            end
            nb_cnt  += int'(peb_next_block[0]);
            rw_cnt  += int'(peb_reset_wei[0]);
            ra_cnt  += int'(peb_reset_act[0]);
            pbw_cnt += int'(gb_pullback_wei);
            pba_cnt += int'(gb_pullback_act);
            if (layer_fnh) begin
                fnh_cnt++;
                in_clear = 1'b1;
            end
            if (pool_clear_up && layer_idx < NWORD) begin
                w   = word_at(layer_idx);
                gp  = iters(w.num_ftrgrp) * iters(w.num_patch);
                fgp = iters(w.num_frame) * gp;
                check_eq("peb_next_block pulses", nb_cnt, int'(stim[2*layer_idx+1]));
                check_eq("peb_reset_wei pulses", rw_cnt, fgp);
                check_eq("peb_reset_act pulses", ra_cnt, gp);
                check_eq("gb_pullback_wei pulses", pbw_cnt, fgp);
                check_eq("gb_pullback_act pulses", pba_cnt, gp);
                check_eq("layer_fnh pulses", fnh_cnt, 1);
                check_eq("gb handshakes by layer end", hs_idx, layer_idx + 1);
                nb_cnt    = 0;
                rw_cnt    = 0;
                ra_cnt    = 0;
                pbw_cnt   = 0;
                pba_cnt   = 0;
                fnh_cnt   = 0;
                in_clear  = 1'b0;
                layer_idx++;
                if (layer_idx % DEPTH == 0) begin
                    check_eq("words accepted", acc_cnt, layer_idx);
                    $display("run %0d done: %0d layers, %0d errors so far",
                             layer_idx / DEPTH - 1, DEPTH, errors);
                end
            end
        end
    end

    // ======================================================================
    // watchdog and main sequence
    // ======================================================================
    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge rst_n);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg_val  = 1'b0;
        cfg_data = '0;
        void'($urandom(32'he75b));
        $readmemh("ccu_stim.txt", stim);
        limit = 500;                        // margin
        for (int n = 0; n < NWORD; n++) begin
            limit += 8 * blocks(word_at(n)) + 40;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int r = 0; r < NRUN; r++) begin
            repeat (3) @(posedge clk);
            #1;
            load_run(r);
            while (layer_idx < (r + 1) * DEPTH) begin
                @(negedge clk);
            end
        end
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: ccu_top.sv
`timescale 1ns/10ps

module ccu_top import ccu_pkg::*; #(
    parameter int NUM_PEB    = 16,
    parameter int FIFO_DEPTH = 4    // layers per run
) (
    input  logic               clk,
    input  logic               rst_n,
    // configuration in
    input  logic               start,
    input  logic               cfg_val,
    input  logic [CFG_W-1:0]   cfg_data,
    output logic               cfg_rdy,
    // global buffer config
    output logic               gb_cfg_val,
    input  logic               gb_cfg_rdy,
    output alloc_t             gb_alloc_wei,
    output alloc_t             gb_alloc_act,
    output loop_wei_t          gb_loop_wei,
    output loop_act_t          gb_loop_act,
    // processing elements
    input  logic [NUM_PEB-1:0] peb_fnh_block,
    output logic [NUM_PEB-1:0] peb_next_block,
    output logic [NUM_PEB-1:0] peb_reset_wei,
    output logic [NUM_PEB-1:0] peb_reset_act,
    // global buffer pullback
    output logic               gb_pullback_wei,
    output logic               gb_pullback_act,
    // pooling
    output logic               layer_fnh,
    input  logic               pool_clear_up
);

    cfg_fifo_if cfg_if ();   // loader -> fifo -> sequencer

    // ======================================================================
    // producer
    // ======================================================================
    cfg_loader cfg_loader_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .cfg_val  (cfg_val),
        .cfg_data (cfg_word_t'(cfg_data)),
        .cfg_rdy  (cfg_rdy),
        .fifo     (cfg_if.producer)
    );

    // one word per layer
    cfg_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) cfg_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (cfg_if.buffer)
    );

    // ======================================================================
    // consumer
    // ======================================================================
    loop_sequencer #(
        .NUM_PEB (NUM_PEB)
    ) loop_sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .fifo            (cfg_if.consumer),
        .peb_fnh_block   (peb_fnh_block),
        .peb_next_block  (peb_next_block),
        .peb_reset_wei   (peb_reset_wei),
        .peb_reset_act   (peb_reset_act),
        .gb_cfg_val      (gb_cfg_val),
        .gb_cfg_rdy      (gb_cfg_rdy),
        .gb_alloc_wei    (gb_alloc_wei),
        .gb_alloc_act    (gb_alloc_act),
        .gb_loop_wei     (gb_loop_wei),
        .gb_loop_act     (gb_loop_act),
        .gb_pullback_wei (gb_pullback_wei),
        .gb_pullback_act (gb_pullback_act),
        .layer_fnh       (layer_fnh),
        .pool_clear_up   (pool_clear_up)
    );

endmodule

// File: cfg_fifo.sv
`timescale 1ns/10ps

module cfg_fifo import ccu_pkg::*; #(
    parameter int FIFO_DEPTH = 4    // power of two, at least 2
) (
    input  logic       clk,
    input  logic       rst_n,
    cfg_fifo_if.buffer fifo
);

    localparam int AW = $clog2(FIFO_DEPTH);

    cfg_word_t   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;   // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign do_push = fifo.push && !fifo.full;
    assign do_pop  = fifo.pop && !fifo.empty;

    // ======================================================================
    // storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= fifo.wr_data;
        end
    end

    // show-ahead, head word always on rd_data
    assign fifo.rd_data = mem[rd_ptr[AW-1:0]];

    // ======================================================================
    // pointers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // same address, wrap bits differ -> full
    assign fifo.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                        (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign fifo.empty = (wr_ptr == rd_ptr);

endmodule

// File: cfg_fifo_if.sv
`timescale 1ns/10ps

interface cfg_fifo_if import ccu_pkg::*; ();

    // write side
    logic      push;       // same-cycle write
    cfg_word_t wr_data;
    logic      full;

    // read side, show-ahead
    logic      pop;
    cfg_word_t rd_data;    // oldest word while not empty
    logic      empty;

    // run control between loader and sequencer
    logic      load_done;  // one cycle, buffer filled
    logic      run_done;   // one cycle, last layer cleared up

    modport producer (
        output push, wr_data, load_done,
        input  full, run_done
    );

    modport buffer (
        input  push, wr_data, pop,
        output rd_data, full, empty
    );

    modport consumer (
        output pop, run_done,
        input  rd_data, empty, load_done
    );

endinterface

// File: cfg_loader.sv
`timescale 1ns/10ps

module cfg_loader import ccu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         cfg_val,
    input  cfg_word_t    cfg_data,
    output logic         cfg_rdy,
    cfg_fifo_if.producer fifo
);

    loader_state_e state;
    loader_state_e state_nxt;
    logic          fill_end;      // buffer just became full while filling
    logic          load_done_q;

    // ======================================================================
    // loader fsm
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            LD_IDLE: begin
                if (start) begin
                    state_nxt = LD_FILL;
                end
            end
            LD_FILL: begin
                if (fill_end) begin
                    state_nxt = LD_HOLD;   // one word per layer loaded
                end
            end
            LD_HOLD: begin
                if (fifo.run_done) begin
                    state_nxt = LD_IDLE;   // all layers consumed
                end
            end
            default: state_nxt = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign fill_end = (state == LD_FILL) && fifo.full;

    // only back-pressure toward the source
    assign cfg_rdy = (state == LD_FILL) && !fifo.full;

    assign fifo.push    = cfg_val && cfg_rdy;  // never while full
    assign fifo.wr_data = cfg_data;

    // one-shot, first cycle of LD_HOLD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_done_q <= 1'b0;
        end else begin
            load_done_q <= fill_end;
        end
    end

    assign fifo.load_done = load_done_q;

endmodule

// File: loop_sequencer.sv
`timescale 1ns/10ps

module loop_sequencer import ccu_pkg::*; #(
    parameter int NUM_PEB = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    cfg_fifo_if.consumer       fifo,
    // processing elements
    input  logic [NUM_PEB-1:0] peb_fnh_block,
    output logic [NUM_PEB-1:0] peb_next_block,
    output logic [NUM_PEB-1:0] peb_reset_wei,
    output logic [NUM_PEB-1:0] peb_reset_act,
    // global buffer config, level handshake
    output logic               gb_cfg_val,
    input  logic               gb_cfg_rdy,
    output alloc_t             gb_alloc_wei,
    output alloc_t             gb_alloc_act,
    output loop_wei_t          gb_loop_wei,
    output loop_act_t          gb_loop_act,
    output logic               gb_pullback_wei,
    output logic               gb_pullback_act,
    // pooling
    output logic               layer_fnh,
    input  logic               pool_clear_up
);

    // loop index, innermost first
    localparam int NLOOP = 4;
    localparam int L_BLK = 0;
    localparam int L_FRM = 1;
    localparam int L_GRP = 2;
    localparam int L_PAT = 3;

    // common counter width, widest field
    localparam int LW_BF = (BLK_W > FRM_W) ? BLK_W : FRM_W;
    localparam int LW_GP = (GRP_W > PAT_W) ? GRP_W : PAT_W;
    localparam int LW    = (LW_BF > LW_GP) ? LW_BF : LW_GP;

    seq_state_e               state;
    seq_state_e               state_nxt;
    cfg_word_t                cur;          // word of the running layer
    logic [NUM_PEB-1:0]       fnh_d;
    logic                     fnh_rise;
    logic [NLOOP-1:0][LW-1:0] cnt;
    logic [NLOOP-1:0][LW-1:0] lim;
    logic [NLOOP-1:0]         inc;
    logic [NLOOP-1:0]         ovf;
    logic                     layer_end;
    logic                     start_d;      // layer start, delayed
    logic                     blk_d;        // block advance, not last
    logic                     frm_d;
    logic                     grp_d;
    logic                     end_d;

    // ======================================================================
    // layer fsm
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            SQ_IDLE: begin
                if (fifo.load_done) begin
                    state_nxt = SQ_POP;
                end
            end
            SQ_POP:  state_nxt = SQ_RUN;
            SQ_RUN: begin
                if (layer_end) begin
                    state_nxt = SQ_WAIT_CLEAR;
                end
            end
            SQ_WAIT_CLEAR: begin
                if (pool_clear_up) begin
                    state_nxt = fifo.empty ? SQ_IDLE : SQ_POP;  // run over or next layer
                end
            end
            default: state_nxt = SQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign fifo.pop      = (state == SQ_POP);
    assign fifo.run_done = (state == SQ_WAIT_CLEAR) && pool_clear_up && fifo.empty;

    // current word, loaded with the pop
    always_ff @(posedge clk) begin
        if (state == SQ_POP) begin
            cur <= fifo.rd_data;
        end
    end

    // ======================================================================
    // nested loops: block < frame < feature group < patch
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fnh_d <= '0;
        end else begin
            fnh_d <= peb_fnh_block;
        end
    end

    // all peb blocks done, rising edge only
    assign fnh_rise = (&peb_fnh_block) && !(&fnh_d);

    assign lim[L_BLK] = LW'(cur.num_block);
    assign lim[L_FRM] = LW'(cur.num_frame);
    assign lim[L_GRP] = LW'(cur.num_ftrgrp);
    assign lim[L_PAT] = LW'(cur.num_patch);

    always_comb begin
        for (int i = 0; i < NLOOP; i++) begin
            ovf[i] = (cnt[i] == lim[i]);
        end
        inc[L_BLK] = fnh_rise && (state == SQ_RUN);
        for (int i = 1; i < NLOOP; i++) begin
            inc[i] = inc[i-1] && ovf[i-1];   // carry into outer loop
        end
    end

    assign layer_end = inc[L_PAT] && ovf[L_PAT];
    assign layer_fnh = layer_end;   // cycle of the final advance

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state == SQ_POP) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < NLOOP; i++) begin
                if (inc[i]) begin
                    cnt[i] <= ovf[i] ? '0 : cnt[i] + 1'b1;  // wrap at limit
                end
            end
        end
    end

    // ======================================================================
    // control pulses, one cycle after the event
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d <= 1'b0;
            blk_d   <= 1'b0;
            frm_d   <= 1'b0;
            grp_d   <= 1'b0;
            end_d   <= 1'b0;
        end else begin
            start_d <= (state == SQ_POP);
            blk_d   <= inc[L_BLK] && !layer_end;
            frm_d   <= inc[L_FRM];
            grp_d   <= inc[L_GRP];
            end_d   <= layer_end;
        end
    end

    // same pulse on every peb bit
    assign peb_next_block = {NUM_PEB{start_d | blk_d}};
    assign peb_reset_wei  = {NUM_PEB{start_d | (frm_d & ~end_d)}};
    assign peb_reset_act  = {NUM_PEB{start_d | (grp_d & ~end_d)}};

    // pullbacks also fire at layer end
    assign gb_pullback_wei = frm_d;
    assign gb_pullback_act = grp_d;

    // ======================================================================
    // global buffer config
    // ======================================================================
    // set by the pop, cleared by ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gb_cfg_val <= 1'b0;
        end else if (state == SQ_POP) begin
            gb_cfg_val <= 1'b1;
        end else if (gb_cfg_rdy) begin
            gb_cfg_val <= 1'b0;
        end
    end

    // held for the whole layer
    assign gb_alloc_wei = cur.alloc_wei;
    assign gb_alloc_act = cur.alloc_act;
    assign gb_loop_wei  = cur.loop_wei;
    assign gb_loop_act  = cur.loop_act;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the ccu testbench with verilator, run it, search the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ccu_tb -f sim.f -o ccu_sim
./obj_dir/ccu_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sim.f
ccu_pkg.sv
cfg_fifo_if.sv
cfg_loader.sv
cfg_fifo.sv
loop_sequencer.sv
ccu_top.sv
ccu_chk.sv
ccu_tb.sv
